//--- crc_params.svh
/* Register offsets are word indexes taken from HADDR[4:2].
   CRC_BUF_DEPTH must be a power of two and at least 2. */
`ifndef CRC_PARAMS_SVH
`define CRC_PARAMS_SVH

//////////////////////////////////////////////////
// Input buffer
//////////////////////////////////////////////////

// Number of data words queued between bus and CRC unit
`define CRC_BUF_DEPTH 4

//////////////////////////////////////////////////
// Reset values
//////////////////////////////////////////////////

`define CRC_RESET_INIT 32'hFFFF_FFFF
// Standard CRC-32 generator, MSB-first form
`define CRC_RESET_POLY 32'h04C1_1DB7
`define CRC_RESET_IDR 8'h00
// 32-bit polynomial, no reversal
`define CRC_RESET_CR 5'h00

// Register map, word offsets
`define CRC_ADDR_DR 3'h0
`define CRC_ADDR_IDR 3'h1
`define CRC_ADDR_CR 3'h2
`define CRC_ADDR_INIT 3'h4
`define CRC_ADDR_POL 3'h5

`endif

//--- crc_pkg.sv
/* Encodings match the CR bit fields; only NONSEQ transfers are served by the slave. */
package crc_pkg;

	// AHB-Lite HTRANS encoding
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} ahb_trans_e;

	// Decoded register of the current data phase
	typedef enum logic [2:0]
	{
		SEL_DR,
		SEL_IDR,
		SEL_CR,
		SEL_INIT,
		SEL_POL,
		SEL_NONE
	} reg_sel_e;

	// CR[4:3], width of the generator polynomial
	typedef enum logic [1:0]
	{
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_e;

	// CR[6:5], bit reversal of the input data
	typedef enum logic [1:0]
	{
		NONE = 2'b00,
		BYTE = 2'b01,
		HALF = 2'b10,
		WORD = 2'b11
	} rev_in_e;

endpackage

//--- host_interface.sv
/* Single NONSEQ transfers only; HRESP is always OKAY.
   Write data is taken straight from HWDATA in the data phase. */
`timescale 1ns/1ns
`include "crc_params.svh"

module host_interface
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic [31:0]             HADDR,
	input  logic [31:0]             HWDATA,
	input  logic [2:0]              HSIZE,
	input  crc_pkg::ahb_trans_e     HTRANS,
	input  logic                    HWRITE,
	input  logic                    HSElx,
	input  logic                    HREADY,
	output logic [31:0]             HRDATA,
	output logic                    HREADYOUT,
	output logic                    HRESP,
	output logic [31:0]             bus_wr,
	output logic [1:0]              bus_size,
	output logic                    buffer_write_en,
	output logic                    crc_init_en,
	output logic                    crc_poly_en,
	output logic                    crc_idr_en,
	output logic                    reset_chain,
	output crc_pkg::poly_size_e     crc_poly_size,
	output crc_pkg::rev_in_e        rev_in_type,
	output logic                    rev_out_type,
	input  logic [31:0]             crc_out,
	input  logic [31:0]             crc_init_out,
	input  logic [31:0]             crc_poly_out,
	input  logic [7:0]              crc_idr_out,
	input  logic                    buffer_full,
	input  logic                    reset_pending,
	input  logic                    read_wait
);

	import crc_pkg::*;

	// Address phase copies
	logic [2:0] haddr_pp;
	logic [1:0] hsize_pp;
	ahb_trans_e htrans_pp;
	logic hwrite_pp;
	logic hselx_pp;

	// CR fields {rev_out, rev_in, poly_size}
	logic [4:0] cr_ff;

	reg_sel_e reg_sel;
	logic sample_bus;
	logic write_en;
	logic read_en;
	logic dr_write;
	logic dr_read;
	logic init_write;
	logic cr_en;
	logic wr_strobe;

	//////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////

	// Only captured when the previous data phase completes
	assign sample_bus = HREADYOUT && HREADY;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			htrans_pp <= IDLE;
			hwrite_pp <= 1'b0;
			hselx_pp  <= 1'b0;
		end
		else if (sample_bus)
		begin
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
			hselx_pp  <= HSElx;
		end
	end

	// Register index and size of the transfer in its data phase
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	always_comb
	begin
		case (haddr_pp)
			`CRC_ADDR_DR:   reg_sel = SEL_DR;
			`CRC_ADDR_IDR:  reg_sel = SEL_IDR;
			`CRC_ADDR_CR:   reg_sel = SEL_CR;
			`CRC_ADDR_INIT: reg_sel = SEL_INIT;
			`CRC_ADDR_POL:  reg_sel = SEL_POL;
			default:        reg_sel = SEL_NONE;
		endcase
	end

	assign write_en   = hselx_pp && hwrite_pp && (htrans_pp == NONSEQ);
	assign read_en    = hselx_pp && !hwrite_pp && (htrans_pp == NONSEQ);
	assign dr_write   = write_en && (reg_sel == SEL_DR);
	assign dr_read    = read_en && (reg_sel == SEL_DR);
	assign init_write = write_en && (reg_sel == SEL_INIT);

	// Wait states: full buffer, DR read before CRC done, INIT during reload
	assign HREADYOUT = !((dr_write && buffer_full) ||
		(dr_read && read_wait) ||
		(init_write && reset_pending));
	assign HRESP = 1'b0;

	// Strobes fire in the last cycle of the data phase
	assign buffer_write_en = dr_write && !buffer_full;
	assign crc_init_en     = init_write && !reset_pending;
	assign crc_idr_en      = write_en && (reg_sel == SEL_IDR);
	assign crc_poly_en     = write_en && (reg_sel == SEL_POL);
	assign cr_en           = write_en && (reg_sel == SEL_CR);
	assign wr_strobe = buffer_write_en || crc_init_en || crc_idr_en || crc_poly_en || cr_en;

	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	//////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_ff <= `CRC_RESET_CR;
		else if (cr_en)
			cr_ff <= HWDATA[7:3];
	end

	// CR bit 0 is self-clearing, it only requests a reload
	assign reset_chain   = cr_en && HWDATA[0];
	assign crc_poly_size = poly_size_e'(cr_ff[1:0]);
	assign rev_in_type   = rev_in_e'(cr_ff[3:2]);
	assign rev_out_type  = cr_ff[4];

	// Read mux
	always_comb
	begin
		case (reg_sel)
			SEL_DR:   HRDATA = crc_out;
			SEL_IDR:  HRDATA = {24'h0, crc_idr_out};
			SEL_CR:   HRDATA = {24'h0, cr_ff, 3'b000};
			SEL_INIT: HRDATA = crc_init_out;
			SEL_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

	// A stalled data phase writes nothing
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		!HREADYOUT |-> !wr_strobe);

endmodule

//--- crc_input_buffer.sv
/* Pushes into a full buffer and pops from an empty one are not allowed.
   Head entry is shown at all times. */
`timescale 1ns/1ns
`include "crc_params.svh"

module crc_input_buffer
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        push,
	input  logic [31:0] push_data,
	input  logic [1:0]  push_size,
	input  logic        pop,
	output logic [31:0] head_data,
	output logic [1:0]  head_size,
	output logic        empty,
	output logic        full
);

	localparam int DEPTH = `CRC_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	// Storage, word and its transfer size
	logic [31:0] data_mem [DEPTH];
	logic [1:0] size_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	//////////////////////////////////////////////////
	// Storage write
	//////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (push)
		begin
			data_mem[wr_ptr] <= push_data;
			size_mem[wr_ptr] <= push_size;
		end
	end

	// Pointers wrap by overflow
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_data = data_mem[rd_ptr];
	assign head_size = size_mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == (PTR_W + 1)'(DEPTH));

	// Bus side must hold off when full
	assert property (@(posedge HCLK) disable iff (!HRESETn) push |-> !full);
	// CRC side must only pop queued words
	assert property (@(posedge HCLK) disable iff (!HRESETn) pop |-> !empty);

endmodule

//--- crc_unit.sv
/* MSB-first CRC, no final XOR; a reload request discards the word in progress.
   INIT and POL use their low bits for widths below 32. */
`timescale 1ns/1ns
`include "crc_params.svh"

module crc_unit
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic [31:0]         head_data,
	input  logic [1:0]          head_size,
	input  logic                empty,
	output logic                pop,
	input  logic                crc_init_en,
	input  logic                crc_poly_en,
	input  logic                crc_idr_en,
	input  logic                reset_chain,
	input  crc_pkg::poly_size_e crc_poly_size,
	input  crc_pkg::rev_in_e    rev_in_type,
	input  logic                rev_out_type,
	input  logic [31:0]         bus_wr,
	output logic [31:0]         crc_out,
	output logic [31:0]         crc_init_out,
	output logic [31:0]         crc_poly_out,
	output logic [7:0]          crc_idr_out,
	output logic                read_wait,
	output logic                reset_pending
);

	import crc_pkg::*;

	logic [31:0] init_ff;
	logic [31:0] poly_ff;
	logic [7:0] idr_ff;
	// CRC kept left-aligned, unused low bits stay zero
	logic [31:0] crc_ff;
	logic [31:0] shift_word;
	logic [2:0] bytes_left;

	logic busy;
	logic [4:0] shamt;
	logic [31:0] top_mask;
	logic [31:0] crc_win;
	logic [31:0] in_reflected;
	logic [31:0] in_aligned;
	logic [2:0] word_bytes;

	// Fold one byte into the CRC, eight shifts
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] data,
		input logic [31:0] poly);
		logic [31:0] r;
		r = crc ^ {data, 24'h0};
		for (int i = 0; i < 8; i++)
		begin
			if (r[31])
				r = {r[30:0], 1'b0} ^ poly;
			else
				r = {r[30:0], 1'b0};
		end
		return r;
	endfunction

	function automatic logic [31:0] bitrev32(input logic [31:0] d);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[31 - i];
		return r;
	endfunction

	// Reversal unit is capped at the transfer width
	function automatic logic [31:0] reflect_in(input logic [31:0] d, input rev_in_e mode,
		input logic [1:0] size);
		logic [31:0] rev8;
		logic [31:0] rev16;
		for (int i = 0; i < 32; i++)
		begin
			rev8[i]  = d[(i / 8) * 8 + 7 - (i % 8)];
			rev16[i] = d[(i / 16) * 16 + 15 - (i % 16)];
		end
		case (mode)
			BYTE:    return rev8;
			HALF:    return (size == 2'b00) ? rev8 : rev16;
			WORD:    return (size == 2'b00) ? rev8 : (size == 2'b01) ? rev16 : bitrev32(d);
			default: return d;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Width alignment and input word
	//////////////////////////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			P16:     shamt = 5'd16;
			P8:      shamt = 5'd24;
			P7:      shamt = 5'd25;
			default: shamt = 5'd0;
		endcase
	end

	assign top_mask = 32'hFFFF_FFFF << shamt;
	assign crc_win  = crc_ff & top_mask;
	// Reversing the whole word reverses within the width and right-aligns
	assign crc_out  = rev_out_type ? bitrev32(crc_win) : (crc_win >> shamt);

	assign in_reflected = reflect_in(head_data, rev_in_type, head_size);

	// Move the valid bytes to the top, first byte out is MSB
	always_comb
	begin
		case (head_size)
			2'b00:
			begin
				in_aligned = {in_reflected[7:0], 24'h0};
				word_bytes = 3'd1;
			end
			2'b01:
			begin
				in_aligned = {in_reflected[15:0], 16'h0};
				word_bytes = 3'd2;
			end
			default:
			begin
				in_aligned = in_reflected;
				word_bytes = 3'd4;
			end
		endcase
	end

	assign busy = (bytes_left != 3'd0);
	assign pop = !busy && !empty && !reset_pending;
	// Pending reload also blocks DR reads
	assign read_wait = busy || !empty || reset_pending;

	//////////////////////////////////////////////////
	// Registers and CRC engine
	//////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_ff <= `CRC_RESET_INIT;
			poly_ff <= `CRC_RESET_POLY;
			idr_ff  <= `CRC_RESET_IDR;
		end
		else
		begin
			if (crc_init_en)
				init_ff <= bus_wr;
			if (crc_poly_en)
				poly_ff <= bus_wr;
			if (crc_idr_en)
				idr_ff <= bus_wr[7:0];
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_ff        <= `CRC_RESET_INIT;
			bytes_left    <= 3'd0;
			reset_pending <= 1'b0;
		end
		else
		begin
			reset_pending <= reset_chain;
			if (reset_pending)
			begin
				crc_ff     <= init_ff << shamt;
				bytes_left <= 3'd0;
			end
			else if (busy)
			begin
				crc_ff     <= fold_byte(crc_ff, shift_word[31:24], poly_ff << shamt);
				bytes_left <= bytes_left - 3'd1;
			end
			else if (pop)
				bytes_left <= word_bytes;
		end
	end

	// Byte shifter, loaded on pop
	always_ff @(posedge HCLK)
	begin
		if (pop)
			shift_word <= in_aligned;
		else if (busy)
			shift_word <= {shift_word[23:0], 8'h0};
	end

	assign crc_init_out = init_ff;
	assign crc_poly_out = poly_ff;
	assign crc_idr_out  = idr_ff;

	// Each popped word keeps the unit busy, so pops are never back to back
	assert property (@(posedge HCLK) disable iff (!HRESETn) pop |=> !pop);

	// INIT stays put until the pending reload has landed
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		reset_pending |-> !crc_init_en);

endmodule

//--- crc_ahb_top.sv
/* AHB-Lite slave of the CRC accelerator; HSElx comes from the external decoder. */
`timescale 1ns/1ns

module crc_ahb_top
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic [31:0]         HADDR,
	input  logic [31:0]         HWDATA,
	input  logic [2:0]          HSIZE,
	input  crc_pkg::ahb_trans_e HTRANS,
	input  logic                HWRITE,
	input  logic                HSElx,
	input  logic                HREADY,
	output logic [31:0]         HRDATA,
	output logic                HREADYOUT,
	output logic                HRESP
);

	import crc_pkg::*;

	// Bus side to buffer
	logic [31:0] bus_wr;
	logic [1:0] bus_size;
	logic buffer_write_en;
	logic buffer_full;

	// Buffer to CRC unit
	logic [31:0] head_data;
	logic [1:0] head_size;
	logic buffer_empty;
	logic buffer_pop;

	// Register strobes, configuration and read-back
	logic crc_init_en;
	logic crc_poly_en;
	logic crc_idr_en;
	logic reset_chain;
	poly_size_e crc_poly_size;
	rev_in_e rev_in_type;
	logic rev_out_type;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0] crc_idr_out;
	logic read_wait;
	logic reset_pending;

	host_interface host_i (.*);

	crc_input_buffer buffer_i
	(
		.HCLK(HCLK), .HRESETn(HRESETn),
		.push(buffer_write_en), .push_data(bus_wr), .push_size(bus_size),
		.pop(buffer_pop), .head_data(head_data), .head_size(head_size),
		.empty(buffer_empty), .full(buffer_full)
	);

	crc_unit crc_i (.*, .empty(buffer_empty), .pop(buffer_pop));

endmodule

//--- tb_crc_ahb.sv
/* Stimulus and expected read data come from crc_stim.txt in the run directory.
   Single-slave bus, so HREADY is tied to HREADYOUT. */
`timescale 1ns/1ns
`include "crc_params.svh"

module tb_crc_ahb;

	import crc_pkg::*;

	localparam int TIMEOUT = 200;

	logic HCLK;
	logic HRESETn;
	logic [31:0] haddr;
	logic [31:0] hwdata;
	logic [2:0] hsize;
	ahb_trans_e htrans;
	logic hwrite;
	logic hselx;
	logic hready;
	logic [31:0] hrdata;
	logic hreadyout;
	logic hresp;

	// Data phase still owed by the slave
	logic pend_valid;
	logic pend_write;
	logic [31:0] pend_exp;

	logic [31:0] rand_state;
	logic timed_out;
	int errors;
	int checks;
	int test_errors;
	int test_checks;
	int cur_test;
	// Longest run of back-to-back DR writes
	int chain_len;
	int max_chain;

	assign hready = hreadyout;

	crc_ahb_top dut_i
	(
		.HCLK(HCLK), .HRESETn(HRESETn), .HADDR(haddr), .HWDATA(hwdata), .HSIZE(hsize),
		.HTRANS(htrans), .HWRITE(hwrite), .HSElx(hselx), .HREADY(hready),
		.HRDATA(hrdata), .HREADYOUT(hreadyout), .HRESP(hresp)
	);

	initial HCLK = 1'b0;
	always #4 HCLK = ~HCLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] r;
		r = x ^ (x << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// One bus cycle, outputs sampled mid-cycle where they are settled
	task automatic bus_cycle(output logic ready, output logic [31:0] rdata, output logic resp);
		@(negedge HCLK);
		ready = hreadyout;
		rdata = hrdata;
		resp  = hresp;
		@(posedge HCLK);
		#1;
	endtask

	// Marks the run as failed, the main sequence stops feeding transfers
	task automatic abort_on_timeout(input string what);
		$display("Timeout: HREADYOUT stayed low during %s in test %0d at %0t", what, cur_test,
			$time);
		errors++;
		test_errors++;
		timed_out = 1'b1;
	endtask

	// Close the data phase, response and read data checked
	task automatic complete_data(input logic [31:0] rdata, input logic resp);
		if (pend_valid)
		begin
			checks++;
			test_checks++;
			assert (resp === 1'b0)
			else
			begin
				$display("[FAIL] %0t HRESP expected 0 got %b", $time, resp);
				errors++;
				test_errors++;
			end
			if (!pend_write)
			begin
				checks++;
				test_checks++;
				assert (rdata === pend_exp)
				else
				begin
					$display("[FAIL] %0t HRDATA expected %h got %h", $time, pend_exp, rdata);
					errors++;
					test_errors++;
				end
			end
		end
		pend_valid = 1'b0;
	endtask

	// Bus goes idle and any open data phase runs to its end
	task automatic flush_bus();
		logic ready;
		logic [31:0] rdata;
		logic resp;
		int n;
		htrans = IDLE;
		hselx  = 1'b0;
		hwrite = 1'b0;
		if (pend_valid && !timed_out)
		begin
			ready = 1'b0;
			n = 0;
			while (!ready && n < TIMEOUT)
			begin
				bus_cycle(ready, rdata, resp);
				n++;
			end
			if (!ready)
				abort_on_timeout("a final data phase");
			else
				complete_data(rdata, resp);
		end
	endtask

	// op bit 0 is write, bit 1 chains onto the previous transfer
	task automatic run_transfer(input logic [31:0] op, input logic [31:0] off,
		input logic [31:0] size, input logic [31:0] data, input logic [31:0] exp);
		logic ready;
		logic [31:0] rdata;
		logic resp;
		int n;
		int gaps;
		if (timed_out)
			return;
		if (!op[1])
		begin
			flush_bus();
			if (timed_out)
				return;
			rand_state = xorshift32(rand_state);
			gaps = int'(rand_state % 3);
			repeat (gaps) bus_cycle(ready, rdata, resp);
		end
		if (op[0] && off == 0)
		begin
			chain_len = op[1] ? chain_len + 1 : 1;
			if (chain_len > max_chain)
				max_chain = chain_len;
		end
		// Address phase
		haddr  = {off[29:0], 2'b00};
		hsize  = size[2:0];
		hwrite = op[0];
		htrans = NONSEQ;
		hselx  = 1'b1;
		ready = 1'b0;
		n = 0;
		while (!ready && n < TIMEOUT)
		begin
			bus_cycle(ready, rdata, resp);
			n++;
		end
		if (!ready)
			abort_on_timeout("an address phase");
		else
		begin
			complete_data(rdata, resp);
			pend_valid = 1'b1;
			pend_write = op[0];
			pend_exp   = exp;
			hwdata = op[0] ? data : 32'h0;
			htrans = IDLE;
			hselx  = 1'b0;
		end
	endtask

	task automatic report_test();
		$display("test %0d: %0d checks, %0d failed", cur_test, test_checks, test_errors);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int fd;
		int rc;
		int t;
		string line;
		logic [31:0] op;
		logic [31:0] off;
		logic [31:0] size;
		logic [31:0] data;
		logic [31:0] exp;
		HRESETn = 1'b0;
		haddr  = 32'h0;
		hwdata = 32'h0;
		hsize  = 3'd2;
		htrans = IDLE;
		hwrite = 1'b0;
		hselx  = 1'b0;
		pend_valid = 1'b0;
		pend_write = 1'b0;
		pend_exp   = 32'h0;
		rand_state = 32'h8e33_6cac;
		timed_out = 1'b0;
		errors = 0;
		checks = 0;
		test_errors = 0;
		test_checks = 0;
		cur_test = 0;
		chain_len = 0;
		max_chain = 0;
		repeat (2) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;
		fd = $fopen("crc_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open crc_stim.txt");
			$display("ERRORS FOUND");
			$finish;
		end
		else
		begin
			while (!$feof(fd) && !timed_out)
			begin
				rc = $fgets(line, fd);
				if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
					continue;
				rc = $sscanf(line, "%d %h %h %h %h %h", t, op, off, size, data, exp);
				if (rc != 6)
					continue;
				// New test, finish and report the previous one
				if (t != cur_test)
				begin
					flush_bus();
					if (cur_test != 0)
						report_test();
					cur_test = t;
					test_checks = 0;
					test_errors = 0;
				end
				run_transfer(op, off, size, data, exp);
			end
			flush_bus();
			report_test();
			$fclose(fd);
			// Back-pressure test must overrun the buffer
			assert (max_chain > `CRC_BUF_DEPTH)
			else
			begin
				$display("Back-to-back DR writes (%0d) did not exceed the buffer depth", max_chain);
				errors++;
			end
			$display("total: %0d checks, %0d errors", checks, errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

//--- crc_stim.txt
# test op offset size data expected (hex), op: 0 rd, 1 wr, 2 chained rd, 3 chained wr
# offset is the word index, size 0 byte, 1 halfword, 2 word
1 0 2 2 00000000 00000000
1 0 4 2 00000000 FFFFFFFF
1 0 5 2 00000000 04C11DB7
1 0 1 2 00000000 00000000
1 0 0 2 00000000 FFFFFFFF
2 1 1 2 12345678 00000000
2 0 1 2 00000000 00000078
2 1 4 2 A5A55A5A 00000000
2 0 4 2 00000000 A5A55A5A
2 1 5 2 12345679 00000000
2 0 5 2 00000000 12345679
2 1 2 2 000000FE 00000000
2 0 2 2 00000000 000000F8
2 1 2 2 00000000 00000000
2 0 2 2 00000000 00000000
3 1 4 2 FFFFFFFF 00000000
3 1 5 2 04C11DB7 00000000
3 1 2 2 00000001 00000000
3 0 0 2 00000000 FFFFFFFF
3 1 0 2 FFFFFFFE 00000000
3 0 0 2 00000000 04C11DB7
3 1 0 2 04C11DB6 00000000
3 1 0 2 04C11DB7 00000000
3 0 0 2 00000000 00000000
3 1 2 2 00000001 00000000
3 0 0 2 00000000 FFFFFFFF
4 1 4 2 00000000 00000000
4 1 5 2 00001021 00000000
4 1 2 2 00000009 00000000
4 0 0 2 00000000 00000000
4 1 0 0 00000001 00000000
4 0 0 2 00000000 00001021
4 1 0 1 00001021 00000000
4 0 0 2 00000000 00000000
4 1 0 1 00000001 00000000
4 0 0 2 00000000 00001021
4 1 5 2 00000007 00000000
4 1 2 2 00000011 00000000
4 1 0 0 00000001 00000000
4 0 0 2 00000000 00000007
4 1 0 0 00000007 00000000
4 0 0 2 00000000 00000000
4 1 5 2 00000009 00000000
4 1 2 2 00000019 00000000
4 1 0 0 00000001 00000000
4 0 0 2 00000000 00000009
5 1 5 2 04C11DB7 00000000
5 1 2 2 00000021 00000000
5 1 0 2 00000080 00000000
5 0 0 2 00000000 04C11DB7
5 1 2 2 00000041 00000000
5 1 0 2 00008000 00000000
5 0 0 2 00000000 04C11DB7
5 1 2 2 00000061 00000000
5 1 0 2 80000000 00000000
5 0 0 2 00000000 04C11DB7
5 1 2 2 00000081 00000000
5 1 0 2 00000001 00000000
5 0 0 2 00000000 EDB88320
6 1 2 2 00000001 00000000
6 1 0 2 00000001 00000000
6 3 0 2 04C11DB7 00000000
6 3 0 2 00000001 00000000
6 3 0 2 04C11DB7 00000000
6 3 0 2 00000001 00000000
6 3 0 2 04C11DB6 00000000
6 2 0 2 00000000 04C11DB7

//--- sources.f
+incdir+.
crc_pkg.sv
host_interface.sv
crc_input_buffer.sv
crc_unit.sv
crc_ahb_top.sv
tb_crc_ahb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_crc_ahb -o sim_crc
./obj_dir/sim_crc | tee sim.log
if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	exit 1
fi
exit 0
